/* common/fp_pkg.sv */
package fp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int N_ADC      = 6;   // lane a -> ch 0..2, lane b -> ch 3..5
	localparam int W_ADC      = 18;
	localparam int W_BUS      = 16;
	localparam int W_ADR      = 8;
	localparam int W_OPP      = 48;  // preprocessor value width
	localparam int N_OPP_W    = 3;   // bus words per preprocessor value
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;

	////////////////////////////////////////////////////////////////////////////
	// endpoint addresses
	////////////////////////////////////////////////////////////////////////////

	// wire-ins
	localparam logic [W_ADR-1:0] ADR_ADC_OS    = 8'h01;
	localparam logic [W_ADR-1:0] ADR_OSF_CD    = 8'h02;
	localparam logic [W_ADR-1:0] ADR_OSF_LOVR  = 8'h03;
	localparam logic [W_ADR-1:0] ADR_OSF_UPD   = 8'h04;
	localparam logic [W_ADR-1:0] ADR_PID_P     = 8'h05;
	localparam logic [W_ADR-1:0] ADR_PID_I     = 8'h06;
	localparam logic [W_ADR-1:0] ADR_PID_D     = 8'h07;
	localparam logic [W_ADR-1:0] ADR_PID_UPD   = 8'h08;
	localparam logic [W_ADR-1:0] ADR_RTR_SRC   = 8'h09;
	localparam logic [W_ADR-1:0] ADR_RTR_DEST  = 8'h0A;
	localparam logic [W_ADR-1:0] ADR_OPP_INIT0 = 8'h0B; // 0x0b..0x0d
	localparam logic [W_ADR-1:0] ADR_OPP_MIN0  = 8'h0E; // 0x0e..0x10
	localparam logic [W_ADR-1:0] ADR_OPP_MAX0  = 8'h11; // 0x11..0x13
	localparam logic [W_ADR-1:0] ADR_OPP_UPD   = 8'h14;
	localparam logic [W_ADR-1:0] ADR_OSF_ACT   = 8'h15;
	localparam logic [W_ADR-1:0] ADR_PID_SETPT = 8'h16;

	// wire-outs
	localparam logic [W_ADR-1:0] ADR_ADC_OUT0  = 8'h20; // one per channel
	localparam logic [W_ADR-1:0] ADR_PIPE_STAT = 8'h3F;

	// trigger-ins
	localparam logic [W_ADR-1:0] ADR_TRIG_CSTART  = 8'h53;
	localparam logic [W_ADR-1:0] ADR_TRIG_PID_CLR = 8'h55;
	localparam logic [W_ADR-1:0] ADR_TRIG_DAC_REF = 8'h56;
	localparam logic [W_ADR-1:0] ADR_TRIG_UPDATE  = 8'h57;
	localparam logic [W_ADR-1:0] ADR_TRIG_RESET   = 8'h58;

	// pipe-out
	localparam logic [W_ADR-1:0] ADR_PIPE = 8'hA3;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [W_ADR-1:0] adr;
		logic [W_BUS-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic             ack;
		logic [W_BUS-1:0] dat;
	} wb_rsp_t;

	// dds path sees one value, the host writes it a word at a time
	typedef union packed {
		logic [W_OPP-1:0]              full;
		logic [N_OPP_W-1:0][W_BUS-1:0] word; // word[0] is the low word
	} opp_word_t;

	typedef struct packed {
		logic [2:0]        adc_os;
		logic [N_ADC-1:0]  osf_activate;
		logic [15:0]       osf_cycle_delay;
		logic [5:0]        osf_log_ovr;
		logic [N_ADC-1:0]  osf_update_en;
		logic [15:0]       pid_setpoint;
		logic signed [15:0] pid_p;
		logic signed [15:0] pid_i;
		logic signed [15:0] pid_d;
		logic [N_ADC-1:0]  pid_update_en;
		logic [3:0]        rtr_src_sel;
		logic [3:0]        rtr_dest_sel;
		opp_word_t         opp_init;
		opp_word_t         opp_min;
		opp_word_t         opp_max;
		logic [3:0]        opp_update_en;
	} fp_params_t;

	typedef struct packed {
		logic             adc_cstart;
		logic [N_ADC-1:0] pid_clear;
		logic             dac_ref_set;
		logic             module_update;
		logic             sys_reset;
	} fp_trig_t;

	typedef enum logic [2:0] {
		REG_WIRE_IN,
		REG_WIRE_OUT,
		REG_TRIGGER,
		REG_PIPE,
		REG_NONE
	} bus_region_t;

endpackage

/* frontpanel/fp_adc_capture.sv */
`timescale 1ns/1ps

module fp_adc_capture (
	input  logic                       clk50_in,
	input  logic                       arst_n,
	input  logic [fp_pkg::N_ADC-1:0]   adc_data_valid,
	input  logic [fp_pkg::W_ADC-1:0]   adc_data_a,
	input  logic [fp_pkg::W_ADC-1:0]   adc_data_b,
	input  logic [fp_pkg::W_ADR-1:0]   adr,
	output logic [fp_pkg::W_BUS-1:0]   rdat,
	output logic [fp_pkg::W_BUS-1:0]   ch0_sample,
	output logic                       ch0_valid
);

	localparam int N_LANE_CH = fp_pkg::N_ADC / 2; // channels per lane

	logic [fp_pkg::W_ADC-1:0] ch_q [fp_pkg::N_ADC];

	////////////////////////////////////////////////////////////////////////////
	// channel registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < fp_pkg::N_ADC; i++)
				ch_q[i] <= '0;
			ch0_valid <= 1'b0;
		end else begin
			for (int i = 0; i < N_LANE_CH; i++) begin
				if (adc_data_valid[i])
					ch_q[i] <= adc_data_a;
				if (adc_data_valid[i + N_LANE_CH]) // lane b, no lockout against lane a
					ch_q[i + N_LANE_CH] <= adc_data_b;
			end
			ch0_valid <= adc_data_valid[0]; // fifo push follows the load
		end
	end

	assign ch0_sample = ch_q[0][fp_pkg::W_ADC-1 -: fp_pkg::W_BUS];

	// wire-out readback, top 16 bits of the sample
	always_comb begin
		rdat = '0;
		for (int i = 0; i < fp_pkg::N_ADC; i++) begin
			if (adr == fp_pkg::ADR_ADC_OUT0 + 8'(i))
				rdat = ch_q[i][fp_pkg::W_ADC-1 -: fp_pkg::W_BUS];
		end
	end

endmodule

/* frontpanel/fp_bus_decode.sv */
`timescale 1ns/1ps

module fp_bus_decode (
	input  logic                      clk50_in,
	input  logic                      arst_n,
	input  fp_pkg::wb_req_t           req,
	output fp_pkg::wb_rsp_t           rsp,
	output logic                      wr_en,
	output logic                      rd_en,
	output fp_pkg::bus_region_t       region,
	output logic [fp_pkg::W_ADR-1:0]  adr,
	output logic [fp_pkg::W_BUS-1:0]  wdat,
	input  logic [fp_pkg::W_BUS-1:0]  rdat_param,
	input  logic [fp_pkg::W_BUS-1:0]  rdat_adc,
	input  logic [fp_pkg::W_BUS-1:0]  rdat_pipe
);

	logic                     ack_q;
	logic                     req_act;
	logic [fp_pkg::W_BUS-1:0] rd_word;

	assign req_act = req.cyc & req.stb;
	assign adr     = req.adr;
	assign wdat    = req.dat;

	// ack one cycle after the request, then one dead cycle
	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_act & ~ack_q;
		end
	end

	assign wr_en = ack_q & req_act & req.we;
	assign rd_en = ack_q & req_act & ~req.we;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (req.adr < 8'h20)
			region = fp_pkg::REG_WIRE_IN;
		else if (req.adr < 8'h40)
			region = fp_pkg::REG_WIRE_OUT;
		else if (req.adr < 8'h80)
			region = fp_pkg::REG_TRIGGER;
		else if (req.adr == fp_pkg::ADR_PIPE)
			region = fp_pkg::REG_PIPE;
		else
			region = fp_pkg::REG_NONE;
	end

	// read mux, triggers are write-only
	always_comb begin
		case (region)
			fp_pkg::REG_WIRE_IN:  rd_word = rdat_param;
			fp_pkg::REG_WIRE_OUT: rd_word = (req.adr == fp_pkg::ADR_PIPE_STAT) ? rdat_pipe : rdat_adc;
			fp_pkg::REG_PIPE:     rd_word = rdat_pipe;
			default:              rd_word = '0;
		endcase
	end

	always_comb begin
		rsp.ack = ack_q;
		rsp.dat = rd_word;
	end

	// one access per two cycles
	a_ack_gap: assert property (@(posedge clk50_in) disable iff (!arst_n)
		rsp.ack |=> !rsp.ack);

endmodule

/* frontpanel/fp_param_regs.sv */
`timescale 1ns/1ps

module fp_param_regs (
	input  logic                      clk50_in,
	input  logic                      arst_n,
	input  logic                      wr_en,
	input  logic [fp_pkg::W_ADR-1:0]  adr,
	input  logic [fp_pkg::W_BUS-1:0]  wdat,
	output fp_pkg::fp_params_t        params,
	output logic [fp_pkg::W_BUS-1:0]  rdat
);

	////////////////////////////////////////////////////////////////////////////
	// wire-in registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			params             <= '0;
			params.osf_log_ovr <= 6'd1; // ratio of 2 out of reset
		end else if (wr_en) begin
			case (adr)
				fp_pkg::ADR_ADC_OS:    params.adc_os          <= wdat[2:0];
				fp_pkg::ADR_OSF_CD:    params.osf_cycle_delay <= wdat;
				fp_pkg::ADR_OSF_LOVR:  params.osf_log_ovr     <= wdat[5:0];
				fp_pkg::ADR_OSF_UPD:   params.osf_update_en   <= wdat[fp_pkg::N_ADC-1:0];
				fp_pkg::ADR_PID_P:     params.pid_p           <= wdat;
				fp_pkg::ADR_PID_I:     params.pid_i           <= wdat;
				fp_pkg::ADR_PID_D:     params.pid_d           <= wdat;
				fp_pkg::ADR_PID_UPD:   params.pid_update_en   <= wdat[fp_pkg::N_ADC-1:0];
				fp_pkg::ADR_RTR_SRC:   params.rtr_src_sel     <= wdat[3:0];
				fp_pkg::ADR_RTR_DEST:  params.rtr_dest_sel    <= wdat[3:0];
				fp_pkg::ADR_OPP_INIT0:         params.opp_init.word[0] <= wdat;
				fp_pkg::ADR_OPP_INIT0 + 8'd1:  params.opp_init.word[1] <= wdat;
				fp_pkg::ADR_OPP_INIT0 + 8'd2:  params.opp_init.word[2] <= wdat;
				fp_pkg::ADR_OPP_MIN0:          params.opp_min.word[0]  <= wdat;
				fp_pkg::ADR_OPP_MIN0 + 8'd1:   params.opp_min.word[1]  <= wdat;
				fp_pkg::ADR_OPP_MIN0 + 8'd2:   params.opp_min.word[2]  <= wdat;
				fp_pkg::ADR_OPP_MAX0:          params.opp_max.word[0]  <= wdat;
				fp_pkg::ADR_OPP_MAX0 + 8'd1:   params.opp_max.word[1]  <= wdat;
				fp_pkg::ADR_OPP_MAX0 + 8'd2:   params.opp_max.word[2]  <= wdat;
				fp_pkg::ADR_OPP_UPD:   params.opp_update_en   <= wdat[3:0];
				fp_pkg::ADR_OSF_ACT:   params.osf_activate    <= wdat[fp_pkg::N_ADC-1:0];
				fp_pkg::ADR_PID_SETPT: params.pid_setpoint    <= wdat;
				default: ; // unmapped, dropped
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rdat = '0;
		case (adr)
			fp_pkg::ADR_ADC_OS:    rdat[2:0]  = params.adc_os;
			fp_pkg::ADR_OSF_CD:    rdat       = params.osf_cycle_delay;
			fp_pkg::ADR_OSF_LOVR:  rdat[5:0]  = params.osf_log_ovr;
			fp_pkg::ADR_OSF_UPD:   rdat[fp_pkg::N_ADC-1:0] = params.osf_update_en;
			fp_pkg::ADR_PID_P:     rdat       = params.pid_p;
			fp_pkg::ADR_PID_I:     rdat       = params.pid_i;
			fp_pkg::ADR_PID_D:     rdat       = params.pid_d;
			fp_pkg::ADR_PID_UPD:   rdat[fp_pkg::N_ADC-1:0] = params.pid_update_en;
			fp_pkg::ADR_RTR_SRC:   rdat[3:0]  = params.rtr_src_sel;
			fp_pkg::ADR_RTR_DEST:  rdat[3:0]  = params.rtr_dest_sel;
			fp_pkg::ADR_OPP_INIT0:         rdat = params.opp_init.word[0];
			fp_pkg::ADR_OPP_INIT0 + 8'd1:  rdat = params.opp_init.word[1];
			fp_pkg::ADR_OPP_INIT0 + 8'd2:  rdat = params.opp_init.word[2];
			fp_pkg::ADR_OPP_MIN0:          rdat = params.opp_min.word[0];
			fp_pkg::ADR_OPP_MIN0 + 8'd1:   rdat = params.opp_min.word[1];
			fp_pkg::ADR_OPP_MIN0 + 8'd2:   rdat = params.opp_min.word[2];
			fp_pkg::ADR_OPP_MAX0:          rdat = params.opp_max.word[0];
			fp_pkg::ADR_OPP_MAX0 + 8'd1:   rdat = params.opp_max.word[1];
			fp_pkg::ADR_OPP_MAX0 + 8'd2:   rdat = params.opp_max.word[2];
			fp_pkg::ADR_OPP_UPD:   rdat[3:0]  = params.opp_update_en;
			fp_pkg::ADR_OSF_ACT:   rdat[fp_pkg::N_ADC-1:0] = params.osf_activate;
			fp_pkg::ADR_PID_SETPT: rdat       = params.pid_setpoint;
			default:               rdat       = '0;
		endcase
	end

endmodule

/* frontpanel/fp_pipe_fifo.sv */
`timescale 1ns/1ps

module fp_pipe_fifo (
	input  logic                      clk50_in,
	input  logic                      arst_n,
	input  logic                      flush,
	input  logic                      push,
	input  logic [fp_pkg::W_BUS-1:0]  din,
	input  logic                      pop,
	output logic [fp_pkg::W_BUS-1:0]  dout,
	output logic [fp_pkg::W_BUS-1:0]  status
);

	logic [fp_pkg::W_BUS-1:0]   mem [fp_pkg::FIFO_DEPTH];
	logic [fp_pkg::FIFO_AW-1:0] wr_ptr;
	logic [fp_pkg::FIFO_AW-1:0] rd_ptr;
	logic [fp_pkg::FIFO_AW:0]   count;  // one bit wider than the pointers
	logic                       ovf_q;
	logic                       empty;
	logic                       full;
	logic                       do_push;
	logic                       do_pop;

	assign empty   = (count == '0);
	assign full    = (count == fp_pkg::FIFO_DEPTH[fp_pkg::FIFO_AW:0]);
	assign do_pop  = pop & ~empty;            // empty reads pop nothing
	assign do_push = push & (~full | do_pop); // a pop frees the slot

	////////////////////////////////////////////////////////////////////////////
	// pointers, count and overflow
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf_q  <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf_q  <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			if (push && !do_push)
				ovf_q <= 1'b1; // sticky until flush
		end
	end

	// storage
	always_ff @(posedge clk50_in) begin
		if (do_push && !flush)
			mem[wr_ptr] <= din;
	end

	assign dout   = empty ? '0 : mem[rd_ptr];
	assign status = {ovf_q, {(fp_pkg::W_BUS - fp_pkg::FIFO_AW - 2){1'b0}}, count};

	a_count_max: assert property (@(posedge clk50_in) disable iff (!arst_n)
		count <= fp_pkg::FIFO_DEPTH);

endmodule

/* frontpanel/fp_trigger_bank.sv */
`timescale 1ns/1ps

module fp_trigger_bank (
	input  logic                      clk50_in,
	input  logic                      arst_n,
	input  logic                      wr_en,
	input  logic [fp_pkg::W_ADR-1:0]  adr,
	input  logic [fp_pkg::W_BUS-1:0]  wdat,
	output fp_pkg::fp_trig_t          trig
);

	// every pulse drops again one cycle after it was set
	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			trig <= '0;
		end else begin
			trig <= '0;
			if (wr_en) begin
				case (adr)
					fp_pkg::ADR_TRIG_CSTART:
						trig.adc_cstart <= wdat[0];
					fp_pkg::ADR_TRIG_PID_CLR:
						trig.pid_clear <= wdat[fp_pkg::N_ADC-1:0]; // one bit per pid channel
					fp_pkg::ADR_TRIG_DAC_REF:
						trig.dac_ref_set <= wdat[0];
					fp_pkg::ADR_TRIG_UPDATE:
						trig.module_update <= wdat[0];
					fp_pkg::ADR_TRIG_RESET:
						trig.sys_reset <= wdat[0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// bus spacing keeps the global update to a single-cycle strobe
	a_update_pulse: assert property (@(posedge clk50_in) disable iff (!arst_n)
		trig.module_update |=> !trig.module_update);

endmodule

/* frontpanel_interface.f */
common/fp_pkg.sv
frontpanel/fp_bus_decode.sv
frontpanel/fp_param_regs.sv
frontpanel/fp_trigger_bank.sv
frontpanel/fp_adc_capture.sv
frontpanel/fp_pipe_fifo.sv
src/frontpanel_interface.sv
tests/tb_frontpanel_interface.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frontpanel_interface \
	-f frontpanel_interface.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Verification passed" sim.log
echo "simulation passed"

/* src/frontpanel_interface.sv */
`timescale 1ns/1ps

module frontpanel_interface (
	input  logic                      clk50_in,
	input  logic                      arst_n,
	input  fp_pkg::wb_req_t           wb_req,
	output fp_pkg::wb_rsp_t           wb_rsp,
	input  logic [fp_pkg::N_ADC-1:0]  adc_data_valid,
	input  logic [fp_pkg::W_ADC-1:0]  adc_data_a,
	input  logic [fp_pkg::W_ADC-1:0]  adc_data_b,
	output fp_pkg::fp_params_t        params,
	output fp_pkg::fp_trig_t          trig
);

	logic                     wr_en;
	logic                     rd_en;
	fp_pkg::bus_region_t      region;
	logic [fp_pkg::W_ADR-1:0] adr;
	logic [fp_pkg::W_BUS-1:0] wdat;
	logic [fp_pkg::W_BUS-1:0] rdat_param;
	logic [fp_pkg::W_BUS-1:0] rdat_adc;
	logic [fp_pkg::W_BUS-1:0] rdat_pipe;
	logic [fp_pkg::W_BUS-1:0] ch0_sample;
	logic                     ch0_valid;
	logic [fp_pkg::W_BUS-1:0] fifo_dout;
	logic [fp_pkg::W_BUS-1:0] fifo_status;
	logic                     param_wr;
	logic                     trig_wr;
	logic                     pipe_pop;

	////////////////////////////////////////////////////////////////////////////
	// strobes qualified by region
	////////////////////////////////////////////////////////////////////////////

	assign param_wr  = wr_en & (region == fp_pkg::REG_WIRE_IN);
	assign trig_wr   = wr_en & (region == fp_pkg::REG_TRIGGER);
	assign pipe_pop  = rd_en & (region == fp_pkg::REG_PIPE);
	assign rdat_pipe = (region == fp_pkg::REG_PIPE) ? fifo_dout : fifo_status; // data or status

	fp_bus_decode u_decode (
		.clk50_in, .arst_n,
		.req        (wb_req),
		.rsp        (wb_rsp),
		.wr_en, .rd_en, .region, .adr, .wdat,
		.rdat_param, .rdat_adc, .rdat_pipe
	);

	fp_param_regs u_params (
		.clk50_in, .arst_n,
		.wr_en (param_wr),
		.adr, .wdat, .params,
		.rdat  (rdat_param)
	);

	fp_trigger_bank u_trig (
		.clk50_in, .arst_n,
		.wr_en (trig_wr),
		.adr, .wdat, .trig
	);

	fp_adc_capture u_adc (
		.clk50_in, .arst_n,
		.adc_data_valid, .adc_data_a, .adc_data_b, .adr,
		.rdat  (rdat_adc),
		.ch0_sample, .ch0_valid
	);

	fp_pipe_fifo u_pipe (
		.clk50_in, .arst_n,
		.flush  (trig.sys_reset),
		.push   (ch0_valid),
		.din    (ch0_sample),
		.pop    (pipe_pop),
		.dout   (fifo_dout),
		.status (fifo_status)
	);

endmodule

/* tests/tb_frontpanel_interface.sv */
`timescale 1ns/1ps

module tb_frontpanel_interface;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_ADC, OP_CHKP, OP_CHKT} op_t;

	// adc entries carry the valid mask in adr, lane a in dat, lane b in dat_b
	typedef struct packed {
		logic [8*12-1:0] name;
		op_t             op;
		logic [7:0]      adr;
		logic [17:0]     dat;
		logic [17:0]     dat_b;
		logic [47:0]     exp;
	} entry_t;

	localparam logic [7:0] WIRE_IN_ADR [13] = '{
		fp_pkg::ADR_ADC_OS, fp_pkg::ADR_OSF_CD, fp_pkg::ADR_OSF_LOVR, fp_pkg::ADR_OSF_UPD,
		fp_pkg::ADR_PID_P, fp_pkg::ADR_PID_I, fp_pkg::ADR_PID_D, fp_pkg::ADR_PID_UPD,
		fp_pkg::ADR_RTR_SRC, fp_pkg::ADR_RTR_DEST, fp_pkg::ADR_OPP_UPD,
		fp_pkg::ADR_OSF_ACT, fp_pkg::ADR_PID_SETPT};
	localparam logic [7:0] OPP_BASE [3] = '{
		fp_pkg::ADR_OPP_INIT0, fp_pkg::ADR_OPP_MIN0, fp_pkg::ADR_OPP_MAX0};
	localparam logic [7:0] STROBE_ADR [4] = '{
		fp_pkg::ADR_TRIG_CSTART, fp_pkg::ADR_TRIG_DAC_REF, fp_pkg::ADR_TRIG_UPDATE,
		fp_pkg::ADR_TRIG_RESET};
	localparam logic [7:0] UNMAPPED_ADR [5] = '{8'h00, 8'h17, 8'h1F, 8'h40, 8'h90};
	localparam logic [5:0] ADC_MASK [4] = '{6'h3F, 6'h05, 6'h38, 6'h12};

	logic                        clk50_in;
	logic                        arst_n;
	fp_pkg::wb_req_t             wb_req;
	fp_pkg::wb_rsp_t             wb_rsp;
	logic [fp_pkg::N_ADC-1:0]    adc_data_valid;
	logic [fp_pkg::W_ADC-1:0]    adc_data_a;
	logic [fp_pkg::W_ADC-1:0]    adc_data_b;
	fp_pkg::fp_params_t          params;
	fp_pkg::fp_trig_t            trig;
	entry_t                      stim_table [$];

	frontpanel_interface UUT (
		.clk50_in, .arst_n, .wb_req, .wb_rsp,
		.adc_data_valid, .adc_data_a, .adc_data_b, .params, .trig
	);

	initial begin
		clk50_in = 1'b0;
		forever #20 clk50_in = ~clk50_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// expected values from the register map
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] field_mask(input logic [7:0] adr);
		case (adr)
			fp_pkg::ADR_ADC_OS:                       return 16'h0007;
			fp_pkg::ADR_OSF_LOVR, fp_pkg::ADR_OSF_UPD,
			fp_pkg::ADR_PID_UPD, fp_pkg::ADR_OSF_ACT:  return 16'h003F; // per channel
			fp_pkg::ADR_RTR_SRC, fp_pkg::ADR_RTR_DEST,
			fp_pkg::ADR_OPP_UPD:                      return 16'h000F;
			default:                                  return 16'hFFFF;
		endcase
	endfunction

	// params field behind a wire-in address
	function automatic logic [47:0] params_field(input logic [7:0] adr);
		case (adr)
			fp_pkg::ADR_ADC_OS:    return 48'(params.adc_os);
			fp_pkg::ADR_OSF_CD:    return 48'(params.osf_cycle_delay);
			fp_pkg::ADR_OSF_LOVR:  return 48'(params.osf_log_ovr);
			fp_pkg::ADR_OSF_UPD:   return 48'(params.osf_update_en);
			fp_pkg::ADR_PID_P:     return 48'($unsigned(params.pid_p));
			fp_pkg::ADR_PID_I:     return 48'($unsigned(params.pid_i));
			fp_pkg::ADR_PID_D:     return 48'($unsigned(params.pid_d));
			fp_pkg::ADR_PID_UPD:   return 48'(params.pid_update_en);
			fp_pkg::ADR_RTR_SRC:   return 48'(params.rtr_src_sel);
			fp_pkg::ADR_RTR_DEST:  return 48'(params.rtr_dest_sel);
			fp_pkg::ADR_OPP_INIT0: return params.opp_init.full; // whole 48-bit view
			fp_pkg::ADR_OPP_MIN0:  return params.opp_min.full;
			fp_pkg::ADR_OPP_MAX0:  return params.opp_max.full;
			fp_pkg::ADR_OPP_UPD:   return 48'(params.opp_update_en);
			fp_pkg::ADR_OSF_ACT:   return 48'(params.osf_activate);
			fp_pkg::ADR_PID_SETPT: return 48'(params.pid_setpoint);
			default:               return '1;
		endcase
	endfunction

	task automatic check_value(input logic [8*12-1:0] name, input logic [7:0] adr,
			input logic [47:0] exp, input logic [47:0] act);
		assert (act === exp) else begin
			$display("ERROR %0s at 0x%02h: expected 0x%0h, actual 0x%0h", name, adr, exp, act);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_entry(input logic [8*12-1:0] name, input op_t op, input logic [7:0] adr,
			input logic [17:0] dat, input logic [17:0] dat_b, input logic [47:0] exp);
		entry_t e;
		e = '{name, op, adr, dat, dat_b, exp};
		stim_table.push_back(e);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus master and adc driver
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_access(input logic we, input logic [7:0] adr, input logic [15:0] dat,
			output logic [15:0] q);
		int n;
		@(posedge clk50_in);
		#2;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		n = 0;
		do begin
			@(negedge clk50_in); // ack and read data settled here
			n++;
		end while (!wb_rsp.ack && n < 20);
		if (!wb_rsp.ack) begin
			$display("bus did not acknowledge the access to 0x%02h within 20 cycles", adr);
			$display("Verification failed");
			$fatal(1, "bus timeout");
		end
		q = wb_rsp.dat;
		@(posedge clk50_in);
		#2;
		wb_req = '0;
	endtask

	task automatic adc_load(input logic [5:0] valid, input logic [17:0] a, input logic [17:0] b);
		@(posedge clk50_in);
		#2;
		adc_data_valid = valid;
		adc_data_a     = a;
		adc_data_b     = b;
		@(posedge clk50_in);
		#2;
		adc_data_valid = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		logic [15:0]      d;
		logic [15:0]      w [3];
		logic [17:0]      sa;
		logic [17:0]      sb;
		logic [5:0]       v;
		logic [17:0]      adc_model [fp_pkg::N_ADC];
		logic [17:0]      pipe_q [$];
		fp_pkg::fp_trig_t te;
		int               pushes;

		for (int i = 0; i < 13; i++) begin
			d = (WIRE_IN_ADR[i] == fp_pkg::ADR_OSF_LOVR) ? 16'd1 : 16'd0;
			add_entry("rst_field", OP_CHKP, WIRE_IN_ADR[i], '0, '0, 48'(d));
			add_entry("rst_read", OP_RD, WIRE_IN_ADR[i], '0, '0, 48'(d));
		end
		for (int i = 0; i < 3; i++) begin
			add_entry("rst_opp", OP_CHKP, OPP_BASE[i], '0, '0, '0);
			add_entry("rst_opp_rd", OP_RD, OPP_BASE[i], '0, '0, '0);
		end
		add_entry("rst_status", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, '0);

		for (int i = 0; i < 13; i++) begin
			d = 16'($urandom);
			add_entry("wi_write", OP_WR, WIRE_IN_ADR[i], 18'(d), '0, '0);
			add_entry("wi_read", OP_RD, WIRE_IN_ADR[i], '0, '0, 48'(d & field_mask(WIRE_IN_ADR[i])));
			add_entry("wi_field", OP_CHKP, WIRE_IN_ADR[i], '0, '0, 48'(d & field_mask(WIRE_IN_ADR[i])));
		end
		for (int i = 0; i < 5; i++)
			add_entry("unmapped", OP_RD, UNMAPPED_ADR[i], '0, '0, '0);

		// three bus words build one 48-bit value
		for (int i = 0; i < 3; i++) begin
			for (int k = 0; k < 3; k++) begin
				w[k] = 16'($urandom);
				add_entry("opp_write", OP_WR, OPP_BASE[i] + 8'(k), 18'(w[k]), '0, '0);
				add_entry("opp_read", OP_RD, OPP_BASE[i] + 8'(k), '0, '0, 48'(w[k]));
			end
			add_entry("opp_full", OP_CHKP, OPP_BASE[i], '0, '0, {w[2], w[1], w[0]});
		end

		te = '0;
		te.pid_clear = 6'($urandom_range(63, 1));
		add_entry("pid_clr_wr", OP_WR, fp_pkg::ADR_TRIG_PID_CLR, 18'(te.pid_clear), '0, '0);
		add_entry("pid_clr", OP_CHKT, fp_pkg::ADR_TRIG_PID_CLR, '0, '0, 48'(te));

		// single-bit strobes, one write each
		for (int i = 0; i < 4; i++) begin
			te = '0;
			case (i)
				0:       te.adc_cstart    = 1'b1;
				1:       te.dac_ref_set   = 1'b1;
				2:       te.module_update = 1'b1;
				default: te.sys_reset     = 1'b1;
			endcase
			add_entry("strobe_wr", OP_WR, STROBE_ADR[i], 18'd1, '0, '0);
			add_entry("strobe", OP_CHKT, STROBE_ADR[i], '0, '0, 48'(te));
		end

		////////////////////////////////////////////////////////////////////////
		// adc capture on lane a (ch 0..2) and lane b (ch 3..5)
		////////////////////////////////////////////////////////////////////////
		pushes = 0;
		for (int c = 0; c < fp_pkg::N_ADC; c++)
			adc_model[c] = '0;
		for (int m = 0; m < 4; m++) begin
			sa = 18'($urandom);
			sb = 18'($urandom);
			v  = ADC_MASK[m];
			add_entry("adc_load", OP_ADC, {2'b00, v}, sa, sb, '0);
			for (int c = 0; c < 3; c++) begin
				if (v[c])
					adc_model[c] = sa;
				if (v[c + 3])
					adc_model[c + 3] = sb;
			end
			if (v[0])
				pushes++; // channel 0 feeds the pipe
		end
		for (int c = 0; c < fp_pkg::N_ADC; c++)
			add_entry("adc_read", OP_RD, fp_pkg::ADR_ADC_OUT0 + 8'(c), '0, '0,
				48'(adc_model[c][17:2]));
		add_entry("adc_pushes", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, 48'(pushes));
		add_entry("sys_rst_wr", OP_WR, fp_pkg::ADR_TRIG_RESET, 18'd1, '0, '0);
		add_entry("sys_rst_st", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, '0);

		// 20 samples into a 16 deep pipe
		for (int n = 0; n < 20; n++) begin
			sa = 18'($urandom);
			add_entry("pipe_load", OP_ADC, 8'h01, sa, '0, '0);
			if (n < fp_pkg::FIFO_DEPTH)
				pipe_q.push_back(sa);
		end
		add_entry("pipe_full", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, 48'(16'h8010));
		for (int n = 0; n < fp_pkg::FIFO_DEPTH; n++)
			add_entry("pipe_pop", OP_RD, fp_pkg::ADR_PIPE, '0, '0, 48'(pipe_q[n][17:2]));
		add_entry("pipe_empty", OP_RD, fp_pkg::ADR_PIPE, '0, '0, '0);
		add_entry("pipe_ovf", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, 48'(16'h8000));
		add_entry("sys_rst_wr", OP_WR, fp_pkg::ADR_TRIG_RESET, 18'd1, '0, '0);
		add_entry("ovf_clear", OP_RD, fp_pkg::ADR_PIPE_STAT, '0, '0, '0);
	endtask

	initial begin
		entry_t      e;
		logic [15:0] rd;

		arst_n         = 1'b0;
		wb_req         = '0;
		adc_data_valid = '0;
		adc_data_a     = '0;
		adc_data_b     = '0;
		void'($urandom(25201));
		build_table();
		repeat (4) @(posedge clk50_in);
		#2;
		arst_n = 1'b1;

		foreach (stim_table[i]) begin
			e = stim_table[i];
			case (e.op)
				OP_WR:  bus_access(1'b1, e.adr, e.dat[15:0], rd);
				OP_RD: begin
					bus_access(1'b0, e.adr, '0, rd);
					check_value(e.name, e.adr, e.exp, 48'(rd));
				end
				OP_ADC: adc_load(e.adr[5:0], e.dat, e.dat_b);
				OP_CHKP: begin
					@(negedge clk50_in);
					check_value(e.name, e.adr, e.exp, params_field(e.adr));
				end
				default: begin
					@(negedge clk50_in); // pulse in the cycle after ack
					check_value(e.name, e.adr, e.exp, 48'(trig));
					@(negedge clk50_in);
					check_value("trig_drop", e.adr, '0, 48'(trig));
				end
			endcase
		end

		$display("Verification passed");
		$finish;
	end

endmodule
